// File: dv/ql_bus_patterns.hex
// cfg_addr_rw_strobes_wdata_rdata_flags_delay, cfg = {size, speed}, bit 4 = no restart
// rw 1 read 0 write F end, strobes {uds,lds}, flags {we,oe,io_sel}, delay 0 = random
// 128k map
00_000000_1_3_0000_0A0A_0_0
00_020000_1_3_0000_5D5D_2_2
00_018000_1_3_0000_1010_1_0
00_010000_1_3_0000_FFFF_0_0
00_060000_1_3_0000_5D5D_2_1
00_03FFFE_0_3_1234_0000_4_0
00_00C000_1_3_0000_0A0A_0_0
// 640k map
04_080000_1_3_0000_5D5D_2_3
04_0C0000_1_3_0000_FFFF_0_0
04_140000_1_3_0000_5D5D_2_0
// 896k map
08_0C0000_1_3_0000_5D5D_2_0
08_100000_1_3_0000_0A0A_0_0
08_01C000_1_3_0000_FFFF_0_0
// 4096k, GoldCard boot with shadow off
0C_000000_1_3_0000_6C6C_0_0
0C_00C000_1_3_0000_6C6C_0_0
0C_400000_1_3_0000_0A0A_0_0
0C_200000_1_3_0000_5D5D_2_2
0C_010000_1_3_0000_5D5D_2_0
0C_800000_1_3_0000_6C6C_0_0
0C_004000_0_3_4E75_0000_4_2
0C_018000_1_3_0000_1010_1_0
0C_01C000_1_3_0000_FFFF_0_0
0C_01C100_1_3_0000_5D5D_2_0
// Shadow on, then off again
0C_01C060_0_2_0000_0000_0_0
0C_004000_1_3_0000_5D5D_2_1
0C_00C000_1_3_0000_0A0A_0_0
0C_000000_1_3_0000_5D5D_2_0
0C_004000_0_3_4E71_0000_0_0
0C_01C064_0_2_0000_0000_0_0
0C_004000_1_3_0000_6C6C_0_0
// Size change without restart keeps the old map
10_080000_1_3_0000_5D5D_2_0
00_080000_1_3_0000_0A0A_0_0
00_000000_F_0_0000_0000_0_0

// File: dv/ql_bus_tb.sv
// QL bus core testbench
// Replays CPU accesses from the pattern table against fixed-tag memory
// models, then checks the clock enables and the core reset sequencer

`timescale 1ns/100ps

module ql_bus_tb;

	localparam int max_pat   = 64;
	localparam int ce_window = 64000;   // 100 refresh periods

	logic                   clk_sys = 1'b0;
	logic                   reset;
	logic                   restart_req;
	ql_bus_pkg::ql_config_t status_cfg;
	ql_bus_pkg::cpu_bus_t   cpu_bus;
	logic [15:0]            ql_rom_rdata;
	logic [15:0]            gc_rom_rdata;
	logic [15:0]            sdram_rdata;
	logic [15:0]            io_rdata;
	logic                   sdram_dtack;
	logic [15:0]            cpu_rdata;
	logic                   cpu_dtack;
	logic                   sdram_we;
	logic                   sdram_oe;
	logic                   io_sel;
	logic [23:1]            sdram_addr;
	logic                   ce_bus_p;
	logic                   ce_bus_n;
	logic                   ce_tick;
	logic                   core_reset;

	logic [79:0] pat [0:max_pat-1];   // One access per entry
	int          n_pat;
	int          cycle_cnt = 0;
	int          cycle_limit;
	int          err_cnt;
	int          test_cnt;
	int          test_fail;
	logic [3:0]  live_cfg;             // Config latched in the DUT

	// Fixed-tag memory models
	assign ql_rom_rdata = 16'h0a0a;
	assign gc_rom_rdata = 16'h6c6c;
	assign sdram_rdata  = 16'h5d5d;
	assign io_rdata     = 16'h1010;

	ql_bus_top #(.div_tick(640), .reset_hold(15)) u_ql_bus_top (
		.clk_sys(clk_sys), .reset(reset), .restart_req(restart_req),
		.status_cfg(status_cfg), .cpu_bus(cpu_bus), .ql_rom_rdata(ql_rom_rdata),
		.gc_rom_rdata(gc_rom_rdata), .sdram_rdata(sdram_rdata), .io_rdata(io_rdata),
		.sdram_dtack(sdram_dtack), .cpu_rdata(cpu_rdata), .cpu_dtack(cpu_dtack),
		.sdram_we(sdram_we), .sdram_oe(sdram_oe), .io_sel(io_sel),
		.sdram_addr(sdram_addr), .ce_bus_p(ce_bus_p), .ce_bus_n(ce_bus_n),
		.ce_tick(ce_tick), .core_reset(core_reset)
	);

	always #5 clk_sys = !clk_sys;   // 10 ns period

	// Run limit
	always @(posedge clk_sys)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, an access or restart never completed", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("FAIL @%0t: %s is %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before)
			$display("%s: ok", name);
		else
		begin
			test_fail++;
			$display("%s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// Address wrap per RAM size code
	function automatic logic [23:0] wrap_mask(input logic [1:0] size);
		case (size)
			2'd0:    return 24'h03ffff;  // 256 KB
			2'd3:    return 24'h7fffff;  // 8 MB
			default: return 24'h0fffff;  // 1 MB
		endcase
	endfunction

	// Pulse restart and count CPU phases until the core leaves reset
	task automatic restart_core(input logic [3:0] cfg);
		int p_pulses;
		int errs;
		errs     = err_cnt;
		p_pulses = 0;
		@(posedge clk_sys);
		status_cfg  <= cfg;
		restart_req <= 1'b1;
		@(posedge clk_sys);
		restart_req <= 1'b0;
		@(negedge clk_sys);
		while (core_reset)
		begin
			if (ce_bus_p)
				p_pulses++;
			@(negedge clk_sys);
		end
		check_value(32'(p_pulses), 32'd15, "core_reset hold in ce_bus_p pulses");
		live_cfg = cfg;
		end_test($sformatf("restart cfg %h", cfg), errs);
	endtask

	// ========================================
	// Pattern accesses
	// ========================================
	task automatic run_pattern(input int idx);
		logic [79:0] p;
		logic [7:0]  cfg_f;
		logic [23:0] addr;
		logic [23:0] exp_addr;
		logic        rd;
		logic [2:0]  exp_flags;
		logic        sdram_acc;
		logic        acked;
		int          wait_cnt;
		int          errs;
		p         = pat[idx];
		cfg_f     = p[79:72];
		addr      = p[71:48];
		rd        = p[44];
		exp_flags = p[6:4];              // we, oe, io_sel
		sdram_acc = exp_flags[2] || exp_flags[1];
		wait_cnt  = int'(p[3:0]);
		if (wait_cnt == 0)
			wait_cnt = int'($urandom % 32'd4);  // Random wait states
		errs = err_cnt;
		if (!cfg_f[4] && cfg_f[3:0] != live_cfg)
			restart_core(cfg_f[3:0]);
		exp_addr = addr & wrap_mask(live_cfg[3:2]);
		if (cfg_f[4])
		begin
			@(posedge clk_sys);
			status_cfg <= cfg_f[3:0];    // Menu change with core running
			@(posedge clk_sys);          // DUT sees the new menu value here
		end
		@(posedge clk_sys);
		cpu_bus.addr  <= addr[23:1];
		cpu_bus.as    <= 1'b1;
		cpu_bus.rw    <= rd;
		cpu_bus.uds   <= p[41];
		cpu_bus.lds   <= p[40];
		cpu_bus.wdata <= p[39:24];
		sdram_dtack   <= (wait_cnt == 0);
		acked = 1'b0;
		while (!acked)
		begin
			@(negedge clk_sys);
			if (rd)
				check_value(32'(cpu_rdata), 32'(p[23:8]), "cpu_rdata");
			check_value(32'({sdram_we, sdram_oe, io_sel}), 32'(exp_flags), "we/oe/io_sel");
			check_value(32'(sdram_addr), 32'(exp_addr[23:1]), "sdram_addr");
			check_value(32'(cpu_dtack), sdram_acc ? 32'(sdram_dtack) : 32'd1, "cpu_dtack");
			acked = cpu_dtack;
			if (!acked)
			begin
				@(posedge clk_sys);
				wait_cnt--;
				sdram_dtack <= (wait_cnt <= 0);
			end
		end
		@(posedge clk_sys);
		cpu_bus.as  <= 1'b0;
		cpu_bus.uds <= 1'b0;
		cpu_bus.lds <= 1'b0;
		sdram_dtack <= 1'b1;
		end_test($sformatf("access %0d %s %h", idx, rd ? "rd" : "wr", addr), errs);
	endtask

	// ========================================
	// Clock enables
	// ========================================
	task automatic run_clock_test(input logic [1:0] speed, input longint fract);
		int     p_cnt;
		int     n_cnt;
		int     t_cnt;
		int     alt_err;
		int     exp_half;
		int     errs;
		logic   last_p;
		logic   seen;
		errs    = err_cnt;
		p_cnt   = 0;
		n_cnt   = 0;
		t_cnt   = 0;
		alt_err = 0;
		seen    = 1'b0;
		last_p  = 1'b0;
		restart_core({2'b00, speed});
		repeat (ce_window)
		begin
			@(negedge clk_sys);
			if (ce_tick)
				t_cnt++;
			if (ce_bus_p && ce_bus_n)
				alt_err++;                        // Never both at once
			else if (ce_bus_p || ce_bus_n)
			begin
				if (seen && last_p == ce_bus_p)
					alt_err++;
				seen   = 1'b1;
				last_p = ce_bus_p;
			end
			if (ce_bus_p)
				p_cnt++;
			if (ce_bus_n)
				n_cnt++;
		end
		// Every other overflow is a p phase
		exp_half = int'(longint'(ce_window) * fract / 64'd65536 / 64'd2);
		check_value(32'(t_cnt), 32'd100, "ce_tick pulses");
		check_value(32'(p_cnt >= exp_half - 1 && p_cnt <= exp_half + 1), 32'd1,
			"ce_bus_p count near overflow count");
		check_value(32'(alt_err), 32'd0, "ce_bus_p/ce_bus_n alternation errors");
		end_test($sformatf("clock enables speed %0d, p %0d n %0d", speed, p_cnt, n_cnt), errs);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		reset       <= 1'b1;
		restart_req <= 1'b0;
		status_cfg  <= '0;
		cpu_bus     <= '0;
		sdram_dtack <= 1'b1;
		err_cnt   = 0;
		test_cnt  = 0;
		test_fail = 0;
		live_cfg  = 4'h0;                  // Latched from status_cfg at reset
		void'($urandom(32'h6506_f4c2));
		$readmemh("dv/ql_bus_patterns.hex", pat);
		n_pat = 0;
		while (n_pat < max_pat && pat[n_pat][47:44] != 4'hf)
			n_pat++;
		cycle_limit = n_pat * 40 + 4 * ce_window + 20000;

		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		while (core_reset)
			@(negedge clk_sys);

		for (int i = 0; i < n_pat; i++)
			run_pattern(i);

		run_clock_test(2'd0, 64'd11702);
		run_clock_test(2'd1, 64'd24966);
		run_clock_test(2'd2, 64'd37449);
		run_clock_test(2'd3, 64'd65536);

		$display("Tests %0d, failed %0d, check errors %0d", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: ql_bus_top.f
source/ql_bus_pkg.sv
source/ql_clock_enables.sv
source/ql_reset_ctrl.sv
source/ql_addr_decode.sv
source/ql_goldcard_shadow.sv
source/ql_read_mux.sv
source/ql_bus_top.sv
dv/ql_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the QL bus core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module ql_bus_tb -f ql_bus_top.f -o ql_bus_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/ql_bus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
	exit 0
fi
exit 1

// File: source/ql_addr_decode.sv
// QL memory map decoder
// Rebuilds the byte address, wraps it for the configured RAM size
// and decodes the QL and GoldCard regions

`timescale 1ns/100ps

module ql_addr_decode (
	input  ql_bus_pkg::cpu_bus_t   cpu_bus,
	input  ql_bus_pkg::ram_size_t  ram_size,
	output ql_bus_pkg::ql_region_t region,
	output logic [23:0]            eff_addr
);

	logic [23:0] addr_mask;
	logic        gc_en;
	logic        bram;
	logic        xram;
	logic        gc_ram1;
	logic        gc_ram2;
	logic        strobe;

	// ========================================
	// Address wrap
	// ========================================
	always_comb
	begin
		case (ram_size)
			ql_bus_pkg::ram_128k:  addr_mask = 24'h03ffff; // 256 KB
			ql_bus_pkg::ram_640k:  addr_mask = 24'h0fffff; // 1 MB
			ql_bus_pkg::ram_896k:  addr_mask = 24'h0fffff;
			ql_bus_pkg::ram_4096k: addr_mask = 24'h7fffff; // 8 MB
		endcase
	end

	// A0 set only for a lower-byte-only access
	assign eff_addr = {cpu_bus.addr, !cpu_bus.uds && cpu_bus.lds} & addr_mask;

	assign gc_en = (ram_size == ql_bus_pkg::ram_4096k);

	// ========================================
	// RAM areas
	// ========================================
	assign bram = (eff_addr[23:17] == 7'h01);            // $20000..$3ffff

	always_comb
	begin
		case (ram_size)
			ql_bus_pkg::ram_640k:  xram = !(|eff_addr[23:20]) && ^eff_addr[19:18];
			ql_bus_pkg::ram_896k:  xram = !(|eff_addr[23:20]) && |eff_addr[19:18];
			ql_bus_pkg::ram_4096k: xram = !(|eff_addr[23:22]) && |eff_addr[21:18];
			ql_bus_pkg::ram_128k:  xram = 1'b0;           // Base RAM only
		endcase
	end

	// SuperGoldCard extra RAM around the I/O window
	assign gc_ram1 = gc_en && (eff_addr[23:15] == 9'h002);              // $10000..$17fff
	assign gc_ram2 = gc_en && (eff_addr[23:14] == 10'h007) && |eff_addr[13:8]; // $1c100..$1ffff

	// ========================================
	// Region flags
	// ========================================
	assign strobe = cpu_bus.as && (cpu_bus.uds || cpu_bus.lds);

	always_comb
	begin
		region.rom         = (eff_addr[23:16] == 8'h00);
		region.ext_rom     = (eff_addr[23:14] == 10'h003);  // $c000..$ffff
		region.os_rom      = region.rom && !region.ext_rom;
		region.ql_io       = (eff_addr[23:14] == 10'h006);  // $18000..$1bfff
		region.gc_io       = gc_en && (eff_addr[23:8] == 16'h01c0);
		region.ram         = bram || xram || gc_ram1 || gc_ram2;
		region.gc_boot_rom = gc_en && (eff_addr[23:16] == 8'h04);  // Boot ROM copy
		region.gc_os_rom   = gc_en && (eff_addr[23:16] == 8'h40);  // QL ROM copy
		region.rd          = strobe && cpu_bus.rw;
		region.wr          = strobe && !cpu_bus.rw;
	end

endmodule

// File: source/ql_bus_pkg.sv
// QL bus core shared definitions
// Config codes, CPU bus and region bundles, clock-enable increments
// and the GoldCard register offsets used across the bus core

package ql_bus_pkg;

	// ========================================
	// Config codes
	// ========================================
	typedef logic [1:0] ram_size_t;
	typedef logic [1:0] cpu_speed_t;

	localparam ram_size_t ram_128k  = 2'd0;
	localparam ram_size_t ram_640k  = 2'd1;
	localparam ram_size_t ram_896k  = 2'd2;
	localparam ram_size_t ram_4096k = 2'd3;   // Also selects GoldCard mode

	localparam cpu_speed_t speed_ql   = 2'd0; // Original 15 MHz bus
	localparam cpu_speed_t speed_16   = 2'd1;
	localparam cpu_speed_t speed_24   = 2'd2;
	localparam cpu_speed_t speed_full = 2'd3; // One phase per clk_sys

	typedef struct packed {
		ram_size_t  ram_size;
		cpu_speed_t cpu_speed;
	} ql_config_t;

	// ========================================
	// Bus bundles
	// ========================================
	typedef struct packed {
		logic [23:1] addr;   // Word address
		logic        as;
		logic        rw;     // High for read
		logic        uds;
		logic        lds;
		logic [15:0] wdata;
	} cpu_bus_t;

	// Select flags, several may be set together
	typedef struct packed {
		logic rom;           // $0000..$ffff
		logic os_rom;        // ROM minus ext ROM
		logic ext_rom;       // $c000..$ffff
		logic ram;           // Any RAM incl. GoldCard RAM
		logic ql_io;
		logic gc_io;
		logic gc_boot_rom;
		logic gc_os_rom;
		logic rd;            // Qualified read strobe
		logic wr;            // Qualified write strobe
	} ql_region_t;

	// ========================================
	// Constants
	// ========================================
	// Phase increments for 84 MHz, 65536 is one carry per clock
	localparam logic [16:0] fract_bus_ql   = 17'd11702;
	localparam logic [16:0] fract_bus_16   = 17'd24966;
	localparam logic [16:0] fract_bus_24   = 17'd37449;
	localparam logic [16:0] fract_bus_full = 17'd65536;

	localparam int div_tick_default   = 640;   // 84 MHz / 640 = 131.25 kHz
	localparam int reset_hold_default = 4095;

	localparam logic [15:0] open_bus_data = 16'hffff;

	localparam logic [7:0] gc_shadow_on_offset  = 8'h60; // glo_rena
	localparam logic [7:0] gc_shadow_off_offset = 8'h64; // glo_rdis

endpackage

// File: source/ql_bus_top.sv
// QL system bus core
// Clock enables, reset sequencing, memory map decode, GoldCard
// shadow register and read mux between the 68000 port and memories

`timescale 1ns/100ps

module ql_bus_top #(
	parameter int div_tick   = ql_bus_pkg::div_tick_default,
	parameter int reset_hold = ql_bus_pkg::reset_hold_default
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   restart_req,
	input  ql_bus_pkg::ql_config_t status_cfg,
	input  ql_bus_pkg::cpu_bus_t   cpu_bus,
	input  logic [15:0]            ql_rom_rdata,
	input  logic [15:0]            gc_rom_rdata,
	input  logic [15:0]            sdram_rdata,
	input  logic [15:0]            io_rdata,
	input  logic                   sdram_dtack,
	output logic [15:0]            cpu_rdata,
	output logic                   cpu_dtack,
	output logic                   sdram_we,
	output logic                   sdram_oe,
	output logic                   io_sel,
	output logic [23:1]            sdram_addr,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_tick,
	output logic                   core_reset
);

	ql_bus_pkg::ql_config_t cfg;       // Latched at restart
	ql_bus_pkg::ql_region_t region;
	logic [23:0]            eff_addr;
	logic                   gc_mode;
	logic                   shadow_on;
	logic                   shadow_read;
	logic                   shadow_write;

	assign gc_mode    = (cfg.ram_size == ql_bus_pkg::ram_4096k);
	assign sdram_addr = eff_addr[23:1];  // Wrapped word address

	ql_clock_enables #(.div_tick(div_tick)) u_ql_clock_enables (
		.clk_sys(clk_sys), .reset(reset), .cpu_speed(cfg.cpu_speed),
		.ce_bus_p(ce_bus_p), .ce_bus_n(ce_bus_n), .ce_tick(ce_tick)
	);

	ql_reset_ctrl #(.reset_hold(reset_hold)) u_ql_reset_ctrl (
		.clk_sys(clk_sys), .reset(reset), .restart_req(restart_req),
		.ce_bus_p(ce_bus_p), .status_cfg(status_cfg), .cfg(cfg),
		.core_reset(core_reset)
	);

	ql_addr_decode u_ql_addr_decode (
		.cpu_bus(cpu_bus), .ram_size(cfg.ram_size), .region(region),
		.eff_addr(eff_addr)
	);

	ql_goldcard_shadow u_ql_goldcard_shadow (
		.clk_sys(clk_sys), .reset(reset), .region(region), .cpu_bus(cpu_bus),
		.shadow_on(shadow_on), .shadow_read(shadow_read), .shadow_write(shadow_write)
	);

	ql_read_mux u_ql_read_mux (
		.region(region), .gc_mode(gc_mode), .shadow_on(shadow_on),
		.shadow_read(shadow_read), .shadow_write(shadow_write),
		.ql_rom_rdata(ql_rom_rdata), .gc_rom_rdata(gc_rom_rdata),
		.sdram_rdata(sdram_rdata), .io_rdata(io_rdata), .sdram_dtack(sdram_dtack),
		.cpu_rdata(cpu_rdata), .cpu_dtack(cpu_dtack), .sdram_we(sdram_we),
		.sdram_oe(sdram_oe), .io_sel(io_sel)
	);

endmodule

// File: source/ql_clock_enables.sv
// QL clock enables
// Fractional phase accumulator for the CPU bus phases and a fixed
// divider for the refresh and RTC tick, all on the rising clk_sys edge

`timescale 1ns/100ps

module ql_clock_enables #(
	parameter int div_tick = ql_bus_pkg::div_tick_default
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_tick
);

	localparam int tick_w = (div_tick > 1) ? $clog2(div_tick) : 1;
	localparam logic [tick_w-1:0] tick_last = tick_w'(div_tick - 1);

	logic [16:0]       fract;     // Phase increment for the speed
	logic [15:0]       phase_acc;
	logic [16:0]       phase_sum; // Carry in bit 16
	logic              bus_pol;   // Next carry goes to p when low
	logic [tick_w-1:0] tick_cnt;

	// ========================================
	// CPU phase enables
	// ========================================
	always_comb
	begin
		case (cpu_speed)
			ql_bus_pkg::speed_ql:   fract = ql_bus_pkg::fract_bus_ql;
			ql_bus_pkg::speed_16:   fract = ql_bus_pkg::fract_bus_16;
			ql_bus_pkg::speed_24:   fract = ql_bus_pkg::fract_bus_24;
			ql_bus_pkg::speed_full: fract = ql_bus_pkg::fract_bus_full;
		endcase
		phase_sum = {1'b0, phase_acc} + fract;
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			phase_acc <= '0;
			bus_pol   <= 1'b0;
			ce_bus_p  <= 1'b0;
			ce_bus_n  <= 1'b0;
		end
		else
		begin
			phase_acc <= phase_sum[15:0];
			ce_bus_p  <= phase_sum[16] && !bus_pol;  // Even overflows
			ce_bus_n  <= phase_sum[16] && bus_pol;   // Odd overflows
			bus_pol   <= bus_pol ^ phase_sum[16];
		end
	end

	// ========================================
	// Refresh / RTC tick
	// ========================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			tick_cnt <= '0;
			ce_tick  <= 1'b0;
		end
		else
		begin
			if (tick_cnt == tick_last)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
			ce_tick <= (tick_cnt == tick_last);  // Once per div_tick
		end
	end

endmodule

// File: source/ql_goldcard_shadow.sv
// GoldCard shadow ROM control
// Register that swaps the OS ROM area to its RAM copy, and the
// qualified shadow read and copy-write strobes

`timescale 1ns/100ps

module ql_goldcard_shadow (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::ql_region_t region,
	input  ql_bus_pkg::cpu_bus_t   cpu_bus,
	output logic                   shadow_on,
	output logic                   shadow_read,
	output logic                   shadow_write
);

	logic [7:0] reg_offset;
	logic       reg_write;

	assign reg_offset = {cpu_bus.addr[7:1], 1'b0};
	// Register writes are upper byte only
	assign reg_write = region.gc_io && region.wr && cpu_bus.uds && !cpu_bus.lds;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			shadow_on <= 1'b0;
		else if (reg_write)
		begin
			if (reg_offset == ql_bus_pkg::gc_shadow_on_offset)
				shadow_on <= 1'b1;
			else if (reg_offset == ql_bus_pkg::gc_shadow_off_offset)
				shadow_on <= 1'b0;
		end
	end

	assign shadow_read  = region.rd && region.os_rom && shadow_on;
	assign shadow_write = region.wr && region.os_rom && !shadow_on;  // Loads the copy

endmodule

// File: source/ql_read_mux.sv
// QL read data and DTACK multiplexer
// Picks CPU read data for QL and GoldCard modes, drives the SDRAM
// and I/O strobes and holds DTACK off for SDRAM accesses

`timescale 1ns/100ps

module ql_read_mux (
	input  ql_bus_pkg::ql_region_t region,
	input  logic                   gc_mode,
	input  logic                   shadow_on,
	input  logic                   shadow_read,
	input  logic                   shadow_write,
	input  logic [15:0]            ql_rom_rdata,
	input  logic [15:0]            gc_rom_rdata,
	input  logic [15:0]            sdram_rdata,
	input  logic [15:0]            io_rdata,
	input  logic                   sdram_dtack,
	output logic [15:0]            cpu_rdata,
	output logic                   cpu_dtack,
	output logic                   sdram_we,
	output logic                   sdram_oe,
	output logic                   io_sel
);

	logic        copy_write;  // OS ROM writes only land in GoldCard mode
	logic        sdram_acc;
	logic [15:0] gc_boot_data;
	logic [15:0] gc_shadow_data;
	logic [15:0] ql_data;

	assign copy_write = gc_mode && shadow_write;

	assign sdram_we = region.wr && (region.ram || copy_write);
	assign sdram_oe = region.rd && (region.ram || shadow_read);
	assign io_sel   = region.ql_io && (region.rd || region.wr);

	// ========================================
	// Read data tables
	// ========================================
	always_comb
	begin
		// GoldCard boot, shadow off
		if (region.rom || region.gc_boot_rom)
			gc_boot_data = gc_rom_rdata;
		else if (region.gc_os_rom)
			gc_boot_data = ql_rom_rdata;
		else if (region.ram)
			gc_boot_data = sdram_rdata;
		else
			gc_boot_data = ql_bus_pkg::open_bus_data;

		// GoldCard running, OS from RAM copy
		if (region.os_rom)
			gc_shadow_data = sdram_rdata;
		else if (region.ext_rom || region.gc_os_rom)
			gc_shadow_data = ql_rom_rdata;
		else if (region.ram)
			gc_shadow_data = sdram_rdata;
		else
			gc_shadow_data = ql_bus_pkg::open_bus_data;

		// Plain QL
		if (region.rom)
			ql_data = ql_rom_rdata;
		else if (region.ram)
			ql_data = sdram_rdata;
		else
			ql_data = ql_bus_pkg::open_bus_data;
	end

	always_comb
	begin
		if (region.ql_io)
			cpu_rdata = io_rdata;          // Mapped in every mode
		else if (gc_mode)
			cpu_rdata = shadow_on ? gc_shadow_data : gc_boot_data;
		else
			cpu_rdata = ql_data;
	end

	// SDRAM cycles wait for the controller, the rest ack at once
	assign sdram_acc = region.ram || shadow_read || copy_write;
	assign cpu_dtack = sdram_acc ? sdram_dtack : 1'b1;

endmodule

// File: source/ql_reset_ctrl.sv
// QL core reset sequencer
// Holds the core in reset for a number of CPU phases after a restart
// and latches the RAM size and CPU speed while reset is held

`timescale 1ns/100ps

module ql_reset_ctrl #(
	parameter int reset_hold = ql_bus_pkg::reset_hold_default
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   restart_req,
	input  logic                   ce_bus_p,
	input  ql_bus_pkg::ql_config_t status_cfg,
	output ql_bus_pkg::ql_config_t cfg,
	output logic                   core_reset
);

	localparam logic [11:0] hold_count = 12'(reset_hold);

	logic [11:0] reset_cnt;

	// Reload on any request, count down in CPU phases
	always_ff @(posedge clk_sys)
	begin
		if (reset || restart_req)
			reset_cnt <= hold_count;
		else if (ce_bus_p && reset_cnt != 12'd0)
			reset_cnt <= reset_cnt - 12'd1;
	end

	assign core_reset = (reset_cnt != 12'd0);

	// Config only follows the menu while the core is in reset,
	// so the memory map cannot move under a running CPU
	always_ff @(posedge clk_sys)
	begin
		if (core_reset)
			cfg <= status_cfg;
	end

endmodule
